// File: Bender.yml
package:
  name: qa_driver

sources:
  - common/qa_drv_pkg.sv
  - rtl/qa_drv_csr.sv
  - fifo_from_host/qa_drv_read_requester.sv
  - fifo_from_host/qa_drv_read_rob.sv
  - fifo_from_host/qa_drv_umf_unpacker.sv
  - rtl/qa_driver.sv
  - target: simulation
    files:
      - bench/qa_driver_tb.sv

// File: bench/qa_driver_tb.sv
`timescale 1ns/1ns

module qa_driver_tb
    import qa_drv_pkg::*;
;

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    typedef struct {
        string       name;
        t_cl_addr    base;
        t_line_count count;
        bit          reorder;
        bit          almf;
        bit          stall;
    } t_row;

    localparam int NUM_ROWS = 6;
    // XOR applied to every chunk of the host memory image
    localparam t_umf CHUNK_XOR = 32'hA5C3_0F96;

    t_row rows [NUM_ROWS] = '{
        '{"in_order",   32'h0000_0100, 16'd12, 1'b0, 1'b0, 1'b0},
        '{"reorder",    32'h0000_2000, 16'd20, 1'b1, 1'b0, 1'b0},
        '{"link_bp",    32'h0000_FFF0, 16'd16, 1'b0, 1'b1, 1'b0},
        '{"client_bp",  32'h0004_0000, 16'd24, 1'b1, 1'b0, 1'b1},
        '{"all_bp",     32'h7FFF_FFF8, 16'd16, 1'b1, 1'b1, 1'b1},
        '{"new_base",   32'h0000_0300, 16'd5,  1'b0, 1'b0, 1'b0}
    };

    // DUT ports
    logic     vl_clk_LPdomain_32ui;
    logic     rst_n;
    t_rx_hdr  c0_rx_hdr;
    t_cl_data c0_rx_data;
    logic     c0_rx_rdvalid;
    logic     c0_rx_cfgvalid;
    logic     c0_tx_almfull;
    t_tx_hdr  c0_tx_hdr;
    logic     c0_tx_rdvalid;
    t_umf     rx_fifo_data;
    logic     rx_fifo_rdy;
    logic     rx_fifo_enable;

    // Bench state
    logic [15:0] lfsr = 16'd43;
    string       cur_name;
    bit          cur_reorder;
    bit          cur_almf;
    bit          cur_stall;
    t_umf        exp_chunks [$];
    t_cl_addr    pend_addr [$];
    t_rob_tag    pend_tag [$];
    t_cl_addr    exp_addr;
    int          reqs_seen;
    int          req_total;
    int          lines_done;
    int          chunk_in_line;
    logic [1:0]  almf_hist;

    qa_driver DUT (
        .vl_clk_LPdomain_32ui (vl_clk_LPdomain_32ui),
        .rst_n                (rst_n),
        .c0_rx_hdr            (c0_rx_hdr),
        .c0_rx_data           (c0_rx_data),
        .c0_rx_rdvalid        (c0_rx_rdvalid),
        .c0_rx_cfgvalid       (c0_rx_cfgvalid),
        .c0_tx_almfull        (c0_tx_almfull),
        .c0_tx_hdr            (c0_tx_hdr),
        .c0_tx_rdvalid        (c0_tx_rdvalid),
        .rx_fifo_data         (rx_fifo_data),
        .rx_fifo_rdy          (rx_fifo_rdy),
        .rx_fifo_enable       (rx_fifo_enable)
    );

    // 10 ns clock
    initial
    begin
        vl_clk_LPdomain_32ui = 1'b0;
        forever #5 vl_clk_LPdomain_32ui = ~vl_clk_LPdomain_32ui;
    end

    // ------------------------------------------------------------
    // Random bits and host memory image
    // ------------------------------------------------------------

    // 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic int take_bits(input int n);
        int          result;
        logic        fb;
        result = 0;
        for (int i = 0; i < n; i++)
        begin
            result = (result << 1) | int'(lfsr[15]);
            fb     = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr   = {lfsr[14:0], fb};
        end
        return result;
    endfunction

    // Chunk j of line a is a*4+j under the XOR pattern
    function automatic t_umf chunk_value(input t_cl_addr a, input int j);
        return ((a << 2) + t_umf'(j)) ^ CHUNK_XOR;
    endfunction

    function automatic t_cl_data make_line(input t_cl_addr a);
        t_cl_data data;
        for (int j = 0; j < 4; j++)
        begin
            data[j*32 +: 32] = chunk_value(a, j);
        end
        return data;
    endfunction

    // Line read as the host sees it, type 4, tag counts up from 0 after reset
    function automatic t_tx_hdr build_req_hdr(input t_cl_addr a, input int n);
        t_tx_hdr h;
        h        = '0;
        h[55:52] = 4'd4;
        h[45:14] = a;
        h[2:0]   = n % 8;
        return h;
    endfunction

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_umf(input string name, input t_umf exp, input t_umf act);
        if (exp !== act)
        begin
            abort_run($sformatf("Mismatch %s chunk: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input t_cl_addr exp, input t_cl_addr act);
        if (exp !== act)
        begin
            abort_run($sformatf("Mismatch %s address: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_hdr(input string name, input t_tx_hdr exp, input t_tx_hdr act);
        if (exp !== act)
        begin
            abort_run($sformatf("Mismatch %s header: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input t_line_count exp,
                               input t_line_count act);
        if (exp !== act)
        begin
            abort_run($sformatf("Mismatch %s requests: expected %0d, actual %0d",
                                name, exp, act));
        end
    endtask

    // ------------------------------------------------------------
    // One clock of host, client and monitors
    // ------------------------------------------------------------
    task automatic step();
        int   idx;
        logic hs;
        logic rdy_next;
        logic almf_next;
        @(posedge vl_clk_LPdomain_32ui);
        // Requests must stop one cycle after almfull is seen registered
        if (c0_tx_rdvalid && almf_hist[1])
        begin
            abort_run($sformatf("%s: read request issued while almost-full was high", cur_name));
        end
        almf_hist = {almf_hist[0], c0_tx_almfull};
        // Request monitor
        if (c0_tx_rdvalid)
        begin
            check_addr(cur_name, exp_addr, c0_tx_hdr[45:14]);
            check_hdr(cur_name, build_req_hdr(exp_addr, req_total), c0_tx_hdr);
            pend_addr.push_back(c0_tx_hdr[45:14]);
            pend_tag.push_back(c0_tx_hdr[2:0]);
            exp_addr++;
            reqs_seen++;
            req_total++;
        end
        if (req_total - lines_done > ROB_SLOTS)
        begin
            abort_run($sformatf("%s: more than 8 lines outstanding", cur_name));
        end
        // Client side chunk monitor
        hs = rx_fifo_rdy && rx_fifo_enable;
        if (hs)
        begin
            if (exp_chunks.size() == 0)
            begin
                abort_run($sformatf("%s: chunk delivered with none expected", cur_name));
            end
            check_umf(cur_name, exp_chunks.pop_front(), rx_fifo_data);
            chunk_in_line = (chunk_in_line + 1) % 4;
            if (chunk_in_line == 0)
            begin
                lines_done++;
            end
        end
        c0_rx_rdvalid  <= 1'b0;
        c0_rx_cfgvalid <= 1'b0;
        // Host answers, in reorder rows out of order and in bursts
        if ((pend_tag.size() != 0) &&
            (!cur_reorder || (pend_tag.size() >= 4) || (take_bits(1) != 0)))
        begin
            idx = cur_reorder ? (take_bits(3) % pend_tag.size()) : 0;
            c0_rx_hdr     <= t_rx_hdr'(pend_tag[idx]);
            c0_rx_data    <= make_line(pend_addr[idx]);
            c0_rx_rdvalid <= 1'b1;
            pend_tag.delete(idx);
            pend_addr.delete(idx);
        end
        // Almost-full bursts
        almf_next = 1'b0;
        if (cur_almf)
        begin
            if (c0_tx_almfull)
                almf_next = (take_bits(1) != 0);
            else
                almf_next = (take_bits(2) == 3);
        end
        c0_tx_almfull <= almf_next;
        // rdy falls after the fourth chunk of a line
        rdy_next = rx_fifo_rdy && !(hs && (chunk_in_line == 0));
        rx_fifo_enable <= rdy_next && (!cur_stall || (take_bits(1) != 0));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        rst_n          = 1'b0;
        c0_rx_hdr      = '0;
        c0_rx_data     = '0;
        c0_rx_rdvalid  = 1'b0;
        c0_rx_cfgvalid = 1'b0;
        c0_tx_almfull  = 1'b0;
        rx_fifo_enable = 1'b0;
        cur_name       = "reset";
        cur_reorder    = 1'b0;
        cur_almf       = 1'b0;
        cur_stall      = 1'b0;
        exp_addr       = '0;
        reqs_seen      = 0;
        req_total      = 0;
        lines_done     = 0;
        chunk_in_line  = 0;
        almf_hist      = '0;
        repeat (10) @(posedge vl_clk_LPdomain_32ui);
        rst_n <= 1'b1;

        // Idle after reset, nothing may move before a config write
        for (int i = 0; i < 20; i++)
        begin
            step();
            if (c0_tx_rdvalid || rx_fifo_rdy)
            begin
                abort_run("output active after reset before any config write");
            end
        end

        foreach (rows[r])
        begin
            cur_name    = rows[r].name;
            cur_reorder = rows[r].reorder;
            cur_almf    = rows[r].almf;
            cur_stall   = rows[r].stall;
            exp_addr    = rows[r].base;
            reqs_seen   = 0;
            for (int i = 0; i < rows[r].count; i++)
            begin
                for (int j = 0; j < 4; j++)
                begin
                    exp_chunks.push_back(chunk_value(rows[r].base + t_cl_addr'(i), j));
                end
            end
            // Base first, then the count that starts the run
            step();
            c0_rx_hdr      <= t_rx_hdr'(CSR_BASE_ADDR);
            c0_rx_data     <= t_cl_data'(rows[r].base);
            c0_rx_cfgvalid <= 1'b1;
            step();
            c0_rx_hdr      <= t_rx_hdr'(CSR_LINE_COUNT);
            c0_rx_data     <= t_cl_data'(rows[r].count);
            c0_rx_cfgvalid <= 1'b1;
            while (exp_chunks.size() != 0)
            begin
                step();
            end
            cur_almf  = 1'b0;
            cur_stall = 1'b0;
            repeat (8) step();
            check_count(cur_name, rows[r].count, t_line_count'(reqs_seen));
        end

        $display("all tests passed");
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        int limit;
        limit = 1000;
        foreach (rows[r])
        begin
            limit += 200 * int'(rows[r].count);
        end
        repeat (limit) @(posedge vl_clk_LPdomain_32ui);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: common/qa_drv_pkg.sv
package qa_drv_pkg;

    // ------------------------------------------------------------
    // Link and client widths
    // ------------------------------------------------------------

    // Line width reduced from the full link width
    localparam int CL_WIDTH        = 128;
    localparam int UMF_WIDTH       = 32;
    localparam int CHUNKS_PER_LINE = CL_WIDTH / UMF_WIDTH;
    localparam int TXHDR_WIDTH     = 61;
    localparam int RXHDR_WIDTH     = 18;

    // Reorder depth and also the number of read credits
    localparam int ROB_SLOTS       = 8;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [31:0]                          t_cl_addr;
    typedef logic [15:0]                          t_line_count;
    typedef logic [$clog2(ROB_SLOTS)-1:0]         t_rob_tag;
    // One extra bit so a full pool of ROB_SLOTS fits
    typedef logic [$clog2(ROB_SLOTS):0]           t_credit;
    typedef logic [$clog2(CHUNKS_PER_LINE)-1:0]   t_chunk_idx;
    typedef logic [CL_WIDTH-1:0]                  t_cl_data;
    typedef logic [UMF_WIDTH-1:0]                 t_umf;
    typedef logic [TXHDR_WIDTH-1:0]               t_tx_hdr;
    typedef logic [RXHDR_WIDTH-1:0]               t_rx_hdr;
    typedef logic [13:0]                          t_csr_addr;
    typedef logic [3:0]                           t_req_type;

    // ------------------------------------------------------------
    // CSR map and request codes
    // ------------------------------------------------------------
    localparam t_csr_addr CSR_BASE_ADDR  = 14'd1;
    // Writing the count kicks off a run
    localparam t_csr_addr CSR_LINE_COUNT = 14'd2;

    localparam t_req_type REQ_RDLINE     = 4'h4;

    // Transmit header field positions
    localparam int TXHDR_TYPE_LSB = 52;
    localparam int TXHDR_ADDR_LSB = 14;
    localparam int TXHDR_TAG_LSB  = 0;

    // ------------------------------------------------------------
    // FSM encodings
    // ------------------------------------------------------------
    typedef enum logic [0:0] {
        REQ_IDLE,
        REQ_ISSUE
    } t_req_state;

    typedef enum logic [0:0] {
        UNP_EMPTY,
        UNP_SEND
    } t_unpack_state;

endpackage

// File: fifo_from_host/qa_drv_read_requester.sv
`timescale 1ns/1ns

module qa_drv_read_requester
    import qa_drv_pkg::*;
(
    input  logic        vl_clk_LPdomain_32ui,
    input  logic        rst_n,
    input  t_cl_addr    cfg_base,
    input  t_line_count cfg_count,
    input  logic        cfg_start,
    // Registered copy of the link almost-full
    input  logic        almfull,
    // One credit back per freed reorder slot
    input  logic        slot_free_pulse,
    output logic        req_valid,
    output t_cl_addr    req_addr,
    output t_rob_tag    req_tag
);

    t_req_state  state;
    t_line_count lines_left;
    t_credit     credits;

    // Issue when the link has room and a slot is reserved for the reply
    assign req_valid = (state == REQ_ISSUE) && !almfull &&
                       (credits != '0) && (lines_left != '0);

    // ------------------------------------------------------------
    // Address walk and line countdown
    // ------------------------------------------------------------
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            state      <= REQ_IDLE;
            req_addr   <= '0;
            lines_left <= '0;
            req_tag    <= '0;
        end
        else
        begin
            case (state)
                REQ_IDLE:
                begin
                    // Zero length runs never leave idle
                    if (cfg_start && (cfg_count != '0))
                    begin
                        req_addr   <= cfg_base;
                        lines_left <= cfg_count;
                        state      <= REQ_ISSUE;
                    end
                end
                default:
                begin
                    if (req_valid)
                    begin
                        req_addr   <= req_addr + 1'b1;
                        lines_left <= lines_left - 1'b1;
                        // Tag keeps running across runs to stay in step with the ROB head
                        req_tag    <= req_tag + 1'b1;
                        if (lines_left == t_line_count'(1))
                        begin
                            state <= REQ_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Credit pool sized to the reorder buffer
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            credits <= t_credit'(ROB_SLOTS);
        end
        else if (req_valid && !slot_free_pulse)
        begin
            credits <= credits - 1'b1;
        end
        else if (!req_valid && slot_free_pulse)
        begin
            credits <= credits + 1'b1;
        end
    end

    // A credit only comes back while one is out
    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        slot_free_pulse |-> (credits != t_credit'(ROB_SLOTS)));

    // More frees than requests would mean the ROB lost track of a slot
    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        credits <= t_credit'(ROB_SLOTS));

endmodule

// File: fifo_from_host/qa_drv_read_rob.sv
`timescale 1ns/1ns

module qa_drv_read_rob
    import qa_drv_pkg::*;
(
    input  logic     vl_clk_LPdomain_32ui,
    input  logic     rst_n,

    // Slot reservation from the requester
    input  logic     req_valid,
    input  t_rob_tag req_tag,

    // Read responses in any order
    input  logic     rsp_valid,
    input  t_rob_tag rsp_tag,
    input  t_cl_data rsp_data,

    // Head line handshake with the unpacker
    input  logic     line_taken,
    output logic     line_valid,
    output t_cl_data line_data,
    output logic     slot_free_pulse
);

    // ------------------------------------------------------------
    // Slot storage
    // ------------------------------------------------------------

    // Pending means requested and still waiting on the host
    logic [ROB_SLOTS-1:0] slot_pending;
    // Valid means data landed and awaits release
    logic [ROB_SLOTS-1:0] slot_valid;
    t_cl_data             slot_data [ROB_SLOTS];
    // Oldest outstanding tag
    t_rob_tag             head;

    // Head slot drives the unpacker directly
    assign line_valid = slot_valid[head];
    assign line_data  = slot_data[head];

    // Line data has no reset
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (rsp_valid)
        begin
            slot_data[rsp_tag] <= rsp_data;
        end
    end

    // Slot state and head pointer
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            slot_pending    <= '0;
            slot_valid      <= '0;
            head            <= '0;
            slot_free_pulse <= 1'b0;
        end
        else
        begin
            if (req_valid)
            begin
                slot_pending[req_tag] <= 1'b1;
            end
            if (rsp_valid)
            begin
                slot_pending[rsp_tag] <= 1'b0;
                slot_valid[rsp_tag]   <= 1'b1;
            end
            // Release the head and step to the next tag in order
            if (line_taken)
            begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            // Credit goes back one cycle after the slot is free
            slot_free_pulse <= line_taken;
        end
    end

    // Host answers only what was asked for
    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        rsp_valid |-> slot_pending[rsp_tag]);

    // Requester credits keep it off busy slots
    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        req_valid |-> !(slot_pending[req_tag] || slot_valid[req_tag]));

endmodule

// File: fifo_from_host/qa_drv_umf_unpacker.sv
`timescale 1ns/1ns

module qa_drv_umf_unpacker
    import qa_drv_pkg::*;
(
    input  logic     vl_clk_LPdomain_32ui,
    input  logic     rst_n,

    // Head of the reorder buffer
    input  logic     line_valid,
    input  t_cl_data line_data,
    output logic     line_taken,

    // Client FIFO
    input  logic     rx_fifo_enable,
    output t_umf     rx_fifo_data,
    output logic     rx_fifo_rdy
);

    t_unpack_state state;
    t_cl_data      line_reg;
    t_chunk_idx    chunk_idx;

    // Chunk out whenever a line is loaded
    assign rx_fifo_rdy  = (state == UNP_SEND);
    // Lowest chunk goes first
    assign rx_fifo_data = line_reg[chunk_idx * UMF_WIDTH +: UMF_WIDTH];

    // ------------------------------------------------------------
    // Load and drain FSM
    // ------------------------------------------------------------
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            state      <= UNP_EMPTY;
            chunk_idx  <= '0;
            line_taken <= 1'b0;
        end
        else
        begin
            line_taken <= 1'b0;
            case (state)
                UNP_EMPTY:
                begin
                    // Skip the old head while its release is still in flight
                    if (line_valid && !line_taken)
                    begin
                        chunk_idx <= '0;
                        state     <= UNP_SEND;
                    end
                end
                default:
                begin
                    if (rx_fifo_enable)
                    begin
                        chunk_idx <= chunk_idx + 1'b1;
                        if (chunk_idx == t_chunk_idx'(CHUNKS_PER_LINE - 1))
                        begin
                            line_taken <= 1'b1;
                            state      <= UNP_EMPTY;
                        end
                    end
                end
            endcase
        end
    end

    // Local copy of the line being drained
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if ((state == UNP_EMPTY) && line_valid && !line_taken)
        begin
            line_reg <= line_data;
        end
    end

    // Client FIFO rule
    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        rx_fifo_enable |-> rx_fifo_rdy);

endmodule

// File: rtl/qa_driver.sv
`timescale 1ns/1ns

module qa_driver
    import qa_drv_pkg::*;
(
    input  logic     vl_clk_LPdomain_32ui,
    input  logic     rst_n,

    // Link channel 0 receive side
    input  t_rx_hdr  c0_rx_hdr,
    input  t_cl_data c0_rx_data,
    input  logic     c0_rx_rdvalid,
    input  logic     c0_rx_cfgvalid,
    input  logic     c0_tx_almfull,

    // Link channel 0 transmit side
    output t_tx_hdr  c0_tx_hdr,
    output logic     c0_tx_rdvalid,

    // Client FIFO
    output t_umf     rx_fifo_data,
    output logic     rx_fifo_rdy,
    input  logic     rx_fifo_enable
);

    // ------------------------------------------------------------
    // Link input registers
    // ------------------------------------------------------------
    t_rx_hdr     rx_hdr_q;
    t_cl_data    rx_data_q;
    logic        rx_rdvalid_q;
    logic        rx_cfgvalid_q;
    logic        almfull_q;

    // Payload needs no reset
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        rx_hdr_q  <= c0_rx_hdr;
        rx_data_q <= c0_rx_data;
    end

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            rx_rdvalid_q  <= 1'b0;
            rx_cfgvalid_q <= 1'b0;
            almfull_q     <= 1'b0;
        end
        else
        begin
            rx_rdvalid_q  <= c0_rx_rdvalid;
            rx_cfgvalid_q <= c0_rx_cfgvalid;
            almfull_q     <= c0_tx_almfull;
        end
    end

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    t_cl_addr    cfg_base;
    t_line_count cfg_count;
    logic        cfg_start;
    logic        req_valid;
    t_cl_addr    req_addr;
    t_rob_tag    req_tag;
    t_rob_tag    rsp_tag;
    logic        slot_free_pulse;
    logic        line_valid;
    t_cl_data    line_data;
    logic        line_taken;
    t_tx_hdr     tx_hdr_next;

    // Read responses carry the slot tag in the low header bits
    assign rsp_tag = t_rob_tag'(rx_hdr_q);

    // Read request header, unused fields stay zero
    always_comb
    begin
        tx_hdr_next = '0;
        tx_hdr_next[TXHDR_TYPE_LSB +: $bits(t_req_type)] = REQ_RDLINE;
        tx_hdr_next[TXHDR_ADDR_LSB +: $bits(t_cl_addr)]  = req_addr;
        tx_hdr_next[TXHDR_TAG_LSB +: $bits(t_rob_tag)]   = req_tag;
    end

    // ------------------------------------------------------------
    // Transmit output register
    // ------------------------------------------------------------
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        c0_tx_hdr <= tx_hdr_next;
    end

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            c0_tx_rdvalid <= 1'b0;
        end
        else
        begin
            c0_tx_rdvalid <= req_valid;
        end
    end

    // Config decode
    qa_drv_csr u_csr (
        .vl_clk_LPdomain_32ui (vl_clk_LPdomain_32ui),
        .rst_n                (rst_n),
        .cfg_valid            (rx_cfgvalid_q),
        .cfg_hdr              (rx_hdr_q),
        .cfg_data             (rx_data_q),
        .cfg_base             (cfg_base),
        .cfg_count            (cfg_count),
        .cfg_start            (cfg_start)
    );

    // Producer of line reads
    qa_drv_read_requester u_requester (
        .vl_clk_LPdomain_32ui (vl_clk_LPdomain_32ui),
        .rst_n                (rst_n),
        .cfg_base             (cfg_base),
        .cfg_count            (cfg_count),
        .cfg_start            (cfg_start),
        .almfull              (almfull_q),
        .slot_free_pulse      (slot_free_pulse),
        .req_valid            (req_valid),
        .req_addr             (req_addr),
        .req_tag              (req_tag)
    );

    // Puts responses back in address order
    qa_drv_read_rob u_rob (
        .vl_clk_LPdomain_32ui (vl_clk_LPdomain_32ui),
        .rst_n                (rst_n),
        .req_valid            (req_valid),
        .req_tag              (req_tag),
        .rsp_valid            (rx_rdvalid_q),
        .rsp_tag              (rsp_tag),
        .rsp_data             (rx_data_q),
        .line_taken           (line_taken),
        .line_valid           (line_valid),
        .line_data            (line_data),
        .slot_free_pulse      (slot_free_pulse)
    );

    // Line to chunk conversion for the client
    qa_drv_umf_unpacker u_unpacker (
        .vl_clk_LPdomain_32ui (vl_clk_LPdomain_32ui),
        .rst_n                (rst_n),
        .line_valid           (line_valid),
        .line_data            (line_data),
        .rx_fifo_enable       (rx_fifo_enable),
        .line_taken           (line_taken),
        .rx_fifo_data         (rx_fifo_data),
        .rx_fifo_rdy          (rx_fifo_rdy)
    );

endmodule

// File: rtl/qa_drv_csr.sv
`timescale 1ns/1ns

module qa_drv_csr
    import qa_drv_pkg::*;
(
    input  logic        vl_clk_LPdomain_32ui,
    input  logic        rst_n,

    // Registered config write from link channel 0
    input  logic        cfg_valid,
    input  t_rx_hdr     cfg_hdr,
    input  t_cl_data    cfg_data,

    // Run parameters for the requester
    output t_cl_addr    cfg_base,
    output t_line_count cfg_count,
    output logic        cfg_start
);

    // CSR address sits in the low header bits
    t_csr_addr csr_addr;

    assign csr_addr = t_csr_addr'(cfg_hdr);

    // Register file and start pulse
    // Unknown addresses fall through with no effect
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            cfg_base  <= '0;
            cfg_count <= '0;
            cfg_start <= 1'b0;
        end
        else
        begin
            // Start is a single cycle strobe
            cfg_start <= 1'b0;
            if (cfg_valid && (csr_addr == CSR_BASE_ADDR))
            begin
                cfg_base <= t_cl_addr'(cfg_data);
            end
            if (cfg_valid && (csr_addr == CSR_LINE_COUNT))
            begin
                cfg_count <= t_line_count'(cfg_data);
                cfg_start <= 1'b1;
            end
        end
    end

endmodule

// File: verilog.f
common/qa_drv_pkg.sv
rtl/qa_drv_csr.sv
fifo_from_host/qa_drv_read_requester.sv
fifo_from_host/qa_drv_read_rob.sv
fifo_from_host/qa_drv_umf_unpacker.sv
rtl/qa_driver.sv
bench/qa_driver_tb.sv
